// File: verilog/cmprs_pkg.sv
/* cmprs_pkg: shared widths, modes, bundles, register map and macroblock timing
   constants for the compressor front end */
package cmprs_pkg;

    typedef logic [7:0]  pix_t;       // one pixel
    typedef logic [11:0] buf_addr_t;  // 2 MSBs select the page
    typedef logic [1:0]  page_t;      // buffer page
    typedef logic [5:0]  mb_dim_t;    // macroblock size minus one
    typedef logic [6:0]  mb_x_t;      // left pixel inside a page
    typedef logic [8:0]  period_t;    // macroblock period counter

    typedef enum logic [2:0] {
        COLOR18 = 3'd0,               // 4:2:0 with 18x18 overlapping tiles
        JP4     = 3'd3,               // 16x16 bayer macroblocks
        JP4DIFF = 3'd4                // same pace as jp4
    } conv_mode_e;

    typedef struct packed {
        conv_mode_e  conv_mode;
        mb_dim_t     mb_w_m1;
        mb_dim_t     mb_h_m1;
        logic [1:0]  tile_width;      // 0:16 1:32 2:64 3:128
        logic        tile_col_width;  // 0:16 1:32
    } cmprs_cfg_t;

    typedef struct packed {
        page_t start_page;
        mb_x_t macroblock_x;
    } mb_cmd_t;

    typedef struct packed {
        pix_t data;
        logic first;                  // first pixel of a macroblock
        logic valid;
    } pix_beat_t;

    localparam int PERIOD_COLOR18 = 384;  // 6 blocks of 64, more than 18*18
    localparam int PERIOD_JP4     = 256;  // 4 blocks of 64, exact
    localparam int PREEND_EARLY   = 6;
    localparam int RELEASE_EARLY  = 16;

    // register map, byte offsets
    localparam logic [3:0] REG_CTRL   = 4'h0;
    localparam logic [3:0] REG_CFG    = 4'h4;
    localparam logic [3:0] REG_CMD    = 4'h8;
    localparam logic [3:0] REG_STATUS = 4'hC;

endpackage

// File: verilog/cmprs_regs.sv
/* cmprs_regs: AXI4-Lite slave with control, configuration, command queue
   and status registers */
`timescale 1ns/1ns

module cmprs_regs (
    input  logic                  xclk,
    input  logic                  arst_n,
    input  logic [3:0]            axi_awaddr,
    input  logic                  axi_awvalid,
    output logic                  axi_awready,
    input  logic [31:0]           axi_wdata,
    input  logic                  axi_wvalid,
    output logic                  axi_wready,
    output logic [1:0]            axi_bresp,
    output logic                  axi_bvalid,
    input  logic                  axi_bready,
    input  logic [3:0]            axi_araddr,
    input  logic                  axi_arvalid,
    output logic                  axi_arready,
    output logic [31:0]           axi_rdata,
    output logic [1:0]            axi_rresp,
    output logic                  axi_rvalid,
    input  logic                  axi_rready,
    output logic                  frame_en,
    output cmprs_pkg::cmprs_cfg_t cfg,
    output cmprs_pkg::mb_cmd_t    cmd,
    output logic                  cmd_push,
    input  logic                  cmd_pending,
    input  logic [15:0]           done_count
);

    logic        wr_hs;       // address and data taken together
    logic        rd_hs;
    logic [31:0] rd_mux;

    assign wr_hs       = axi_awvalid && axi_wvalid && !axi_bvalid;
    assign rd_hs       = axi_arvalid && !axi_rvalid;
    assign axi_awready = wr_hs;
    assign axi_wready  = wr_hs;
    assign axi_arready = rd_hs;
    assign axi_bresp   = 2'b00;  // always okay
    assign axi_rresp   = 2'b00;

    always_comb begin
        case (axi_araddr)
            cmprs_pkg::REG_CTRL:   rd_mux = {31'b0, frame_en};
            cmprs_pkg::REG_CFG:    rd_mux = {{(32 - $bits(cfg)){1'b0}}, cfg};
            cmprs_pkg::REG_CMD:    rd_mux = {{(32 - $bits(cmd)){1'b0}}, cmd};
            cmprs_pkg::REG_STATUS: rd_mux = {15'b0, cmd_pending, done_count};
            default:               rd_mux = 32'b0;
        endcase
    end

    always_ff @(posedge xclk or negedge arst_n) begin
        if (!arst_n) begin
            frame_en   <= 1'b0;
            cfg        <= '0;
            cmd        <= '0;
            cmd_push   <= 1'b0;
            axi_bvalid <= 1'b0;
        end else begin
            cmd_push <= 1'b0;
            if (wr_hs) begin
                axi_bvalid <= 1'b1;                       // response next cycle
                case (axi_awaddr)
                    cmprs_pkg::REG_CTRL: frame_en <= axi_wdata[0];
                    cmprs_pkg::REG_CFG:  cfg <= cmprs_pkg::cmprs_cfg_t'(axi_wdata[$bits(cfg)-1:0]);
                    cmprs_pkg::REG_CMD: begin
                        if (!cmd_pending && frame_en) begin  // full queue drops it
                            cmd      <= cmprs_pkg::mb_cmd_t'(axi_wdata[$bits(cmd)-1:0]);
                            cmd_push <= 1'b1;
                        end
                    end
                    default: ;                            // status is read only
                endcase
            end else if (axi_bready) begin
                axi_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge xclk or negedge arst_n) begin
        if (!arst_n) begin
            axi_rvalid <= 1'b0;
        end else if (rd_hs) begin
            axi_rvalid <= 1'b1;
        end else if (axi_rready) begin
            axi_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge xclk) begin
        if (rd_hs) axi_rdata <= rd_mux;  // held while rvalid waits
    end

endmodule

// File: verilog/cmprs_mb_sequencer.sv
/* cmprs_mb_sequencer: one-deep macroblock command queue, launches the reader
   so that back to back macroblocks start one period apart */
`timescale 1ns/1ns

module cmprs_mb_sequencer (
    input  logic               xclk,
    input  logic               arst_n,
    input  logic               frame_en,
    input  cmprs_pkg::mb_cmd_t cmd,
    input  logic               cmd_push,
    input  logic               mb_pre_end,
    output logic               mb_pre_start,
    output cmprs_pkg::mb_cmd_t mb_cmd,
    output logic               cmd_pending
);

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_BUSY,
        SEQ_BUSY_PENDING
    } seq_state_e;

    seq_state_e         state;
    cmprs_pkg::mb_cmd_t pend_cmd;   // waiting command
    logic [2:0]         wait_cnt;   // gap from pre_end to the period end
    logic               launch;

    assign cmd_pending = (state == SEQ_BUSY_PENDING);
    assign launch      = (wait_cnt == 3'd1);  // last cycle of the running period

    always_ff @(posedge xclk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= SEQ_IDLE;
            mb_pre_start <= 1'b0;
            wait_cnt     <= '0;
        end else if (!frame_en) begin
            state        <= SEQ_IDLE;      // drops any pending command
            mb_pre_start <= 1'b0;
            wait_cnt     <= '0;
        end else begin
            mb_pre_start <= 1'b0;
            if (mb_pre_end)            wait_cnt <= 3'(cmprs_pkg::PREEND_EARLY - 1);
            else if (wait_cnt != '0)   wait_cnt <= wait_cnt - 3'd1;
            case (state)
                SEQ_IDLE: begin
                    if (cmd_push) begin
                        mb_pre_start <= 1'b1;  // idle, start at once
                        state        <= SEQ_BUSY;
                    end
                end
                SEQ_BUSY: begin
                    if (cmd_push && launch) mb_pre_start <= 1'b1;  // arrives as period ends
                    else if (cmd_push)      state <= SEQ_BUSY_PENDING;
                    else if (launch)        state <= SEQ_IDLE;  // period over, queue empty
                end
                SEQ_BUSY_PENDING: begin
                    if (launch) begin
                        mb_pre_start <= 1'b1;
                        state        <= SEQ_BUSY;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge xclk) begin
        if (cmd_push && (state == SEQ_IDLE || (state == SEQ_BUSY && launch))) mb_cmd <= cmd;
        if (cmd_push && state == SEQ_BUSY)    pend_cmd <= cmd;
        if (launch && state == SEQ_BUSY_PENDING) mb_cmd <= pend_cmd;
    end

endmodule

// File: verilog/cmprs_pixel_buf_iface.sv
/* cmprs_pixel_buf_iface: walks the tile buffer addresses of one macroblock,
   aligns the read data with its latency and paces the compressor */
`timescale 1ns/1ns

module cmprs_pixel_buf_iface (
    input  logic                  xclk,
    input  logic                  arst_n,
    input  logic                  frame_en,
    input  cmprs_pkg::cmprs_cfg_t cfg,
    input  logic                  mb_pre_start,
    input  cmprs_pkg::mb_cmd_t    mb_cmd,
    input  cmprs_pkg::pix_t       buf_di,
    output cmprs_pkg::buf_addr_t  buf_ra,
    output logic [1:0]            buf_rd,
    output logic                  mb_pre_end,
    output logic                  mb_release_buf,
    output cmprs_pkg::pix_beat_t  beat
);

    logic [2:0]          buf_re;     // re, regen, data ready
    logic [2:0]          start_mark; // run start, carried down with re
    cmprs_pkg::mb_cmd_t  cmd_r;      // macroblock under read
    cmprs_pkg::mb_dim_t  col_x;      // pixel column in the macroblock
    cmprs_pkg::mb_dim_t  row_y;      // pixel row in the macroblock
    cmprs_pkg::period_t  period_cntr;
    logic                last_col;
    logic                run_end;    // last address of the run
    logic [7:0]          p;          // x within the start page, may spill over
    logic [2:0]          t_sh;       // log2 of tile width
    logic [2:0]          w_sh;       // log2 of column width
    logic [7:0]          p_tile;     // x inside its tile
    logic [2:0]          col_idx;    // tile column index
    logic [9:0]          col_stride; // column width times macroblock height
    logic [9:0]          page_off;
    cmprs_pkg::page_t    page;

    assign last_col = (col_x == cfg.mb_w_m1);
    assign run_end  = last_col && (row_y == cfg.mb_h_m1);
    assign buf_rd   = buf_re[1:0];

    // address of pixel (col_x, row_y)
    always_comb begin
        t_sh       = 3'd4 + {1'b0, cfg.tile_width};
        w_sh       = 3'd4 + {2'b0, cfg.tile_col_width};
        p          = {1'b0, cmd_r.macroblock_x} + {2'b0, col_x};
        page       = cmd_r.start_page + 2'(p >> t_sh);     // moves on at tile edge
        p_tile     = p & ((8'd1 << t_sh) - 8'd1);
        col_idx    = 3'(p_tile >> w_sh);
        col_stride = 10'(({4'b0, cfg.mb_h_m1} + 10'd1) << w_sh);
        page_off   = 10'({7'b0, col_idx} * col_stride)
                   + 10'({4'b0, row_y} << w_sh)
                   + 10'(p & ((8'd1 << w_sh) - 8'd1));
        buf_ra     = {page, page_off};
    end

    always_ff @(posedge xclk or negedge arst_n) begin
        if (!arst_n) begin
            buf_re <= '0;
        end else if (!frame_en) begin
            buf_re <= '0;
        end else begin
            if (mb_pre_start) buf_re[0] <= 1'b1;  // run starts next cycle
            else if (run_end) buf_re[0] <= 1'b0;
            buf_re[2:1] <= buf_re[1:0];
        end
    end

    // row and column walk, rows restart at the start page
    always_ff @(posedge xclk) begin
        if (mb_pre_start) begin
            cmd_r <= mb_cmd;
            col_x <= '0;
            row_y <= '0;
        end else if (buf_re[0]) begin
            if (last_col) begin
                col_x <= '0;
                row_y <= row_y + 6'd1;
            end else begin
                col_x <= col_x + 6'd1;
            end
        end
    end

    // macroblock period, loaded from the colour mode
    always_ff @(posedge xclk or negedge arst_n) begin
        if (!arst_n) begin
            period_cntr    <= '0;
            mb_pre_end     <= 1'b0;
            mb_release_buf <= 1'b0;
        end else if (!frame_en) begin
            period_cntr    <= '0;
            mb_pre_end     <= 1'b0;
            mb_release_buf <= 1'b0;
        end else begin
            if (mb_pre_start) begin
                case (cfg.conv_mode)
                    cmprs_pkg::COLOR18: period_cntr <= 9'(cmprs_pkg::PERIOD_COLOR18 - 1);
                    default:            period_cntr <= 9'(cmprs_pkg::PERIOD_JP4 - 1);
                endcase
            end else if (period_cntr != '0) begin
                period_cntr <= period_cntr - 9'd1;
            end
            mb_pre_end     <= (period_cntr == 9'(cmprs_pkg::PREEND_EARLY + 1));
            mb_release_buf <= (period_cntr == 9'(cmprs_pkg::RELEASE_EARLY + 1));
        end
    end

    // back to back runs leave no gap in re, so the first data beat comes
    // from a marker carried down a delay line of the same length
    always_ff @(posedge xclk or negedge arst_n) begin
        if (!arst_n) start_mark <= '0;
        else         start_mark <= {start_mark[1:0], mb_pre_start && frame_en};
    end

    always_ff @(posedge xclk or negedge arst_n) begin
        if (!arst_n) begin
            beat.valid <= 1'b0;
            beat.first <= 1'b0;
        end else if (!frame_en) begin
            beat.valid <= 1'b0;
            beat.first <= 1'b0;
        end else begin
            beat.valid <= buf_re[2];
            beat.first <= buf_re[2] && start_mark[2];  // run start reaches data stage
            if (buf_re[2]) beat.data <= buf_di;
        end
    end

endmodule

// File: verilog/cmprs_tile_buf.sv
/* cmprs_tile_buf: 4096x8 tile buffer, write port from the memory side and a
   two stage read port (array register, then output register) */
`timescale 1ns/1ns

module cmprs_tile_buf (
    input  logic                 xclk,
    input  logic                 wr_en,
    input  cmprs_pkg::buf_addr_t wr_addr,
    input  cmprs_pkg::pix_t      wr_data,
    input  cmprs_pkg::buf_addr_t ra,
    input  logic [1:0]           rd,     // {regen, re}
    output cmprs_pkg::pix_t      rdata
);

    cmprs_pkg::pix_t mem [4096];
    cmprs_pkg::pix_t word_r;              // first read stage

    always_ff @(posedge xclk) begin
        if (wr_en) mem[wr_addr] <= wr_data;
    end

    always_ff @(posedge xclk) begin
        if (rd[0]) word_r <= mem[ra];
        if (rd[1]) rdata  <= word_r;     // output register
    end

endmodule

// File: verilog/cmprs_pixel_out.sv
/* cmprs_pixel_out: output register of the pixel stream, counts finished
   macroblocks for status */
`timescale 1ns/1ns

module cmprs_pixel_out (
    input  logic                 xclk,
    input  logic                 arst_n,
    input  logic                 frame_en,
    input  cmprs_pkg::pix_beat_t beat,
    output cmprs_pkg::pix_t      pix_data,
    output logic                 pix_first,
    output logic                 pix_valid,
    output logic [15:0]          done_count
);

    logic mb_done;  // last pixel now on the output

    // valid falls, or a new macroblock follows without a gap
    assign mb_done = pix_valid && (!beat.valid || beat.first);

    always_ff @(posedge xclk or negedge arst_n) begin
        if (!arst_n) begin
            pix_valid  <= 1'b0;
            pix_first  <= 1'b0;
            done_count <= '0;
        end else if (!frame_en) begin
            pix_valid  <= 1'b0;
            pix_first  <= 1'b0;
            done_count <= '0;
        end else begin
            pix_valid <= beat.valid;
            pix_first <= beat.first;
            if (mb_done) done_count <= done_count + 16'd1;
        end
    end

    always_ff @(posedge xclk) begin
        if (beat.valid) pix_data <= beat.data;
    end

endmodule

// File: verilog/cmprs_front.sv
/* cmprs_front: compressor front end, register port, macroblock sequencer,
   tile buffer reader and pixel output stage */
`timescale 1ns/1ns

module cmprs_front (
    input  logic                 xclk,
    input  logic                 arst_n,
    input  logic [3:0]           axi_awaddr,
    input  logic                 axi_awvalid,
    output logic                 axi_awready,
    input  logic [31:0]          axi_wdata,
    input  logic                 axi_wvalid,
    output logic                 axi_wready,
    output logic [1:0]           axi_bresp,
    output logic                 axi_bvalid,
    input  logic                 axi_bready,
    input  logic [3:0]           axi_araddr,
    input  logic                 axi_arvalid,
    output logic                 axi_arready,
    output logic [31:0]          axi_rdata,
    output logic [1:0]           axi_rresp,
    output logic                 axi_rvalid,
    input  logic                 axi_rready,
    input  logic                 buf_wr_en,
    input  cmprs_pkg::buf_addr_t buf_wr_addr,
    input  cmprs_pkg::pix_t      buf_wr_data,
    output cmprs_pkg::pix_t      pix_data,
    output logic                 pix_first,
    output logic                 pix_valid,
    output logic                 mb_release_buf
);

    logic                  frame_en;
    cmprs_pkg::cmprs_cfg_t cfg;
    cmprs_pkg::mb_cmd_t    cmd;        // from the register
    cmprs_pkg::mb_cmd_t    mb_cmd;     // launched one
    logic                  cmd_push;
    logic                  cmd_pending;
    logic [15:0]           done_count;
    logic                  mb_pre_start;
    logic                  mb_pre_end;
    cmprs_pkg::buf_addr_t  buf_ra;
    logic [1:0]            buf_rd;
    cmprs_pkg::pix_t       buf_di;
    cmprs_pkg::pix_beat_t  beat;

    cmprs_regs cmprs_regs_inst (
        .xclk, .arst_n,
        .axi_awaddr, .axi_awvalid, .axi_awready, .axi_wdata, .axi_wvalid, .axi_wready,
        .axi_bresp, .axi_bvalid, .axi_bready,
        .axi_araddr, .axi_arvalid, .axi_arready, .axi_rdata, .axi_rresp, .axi_rvalid,
        .axi_rready,
        .frame_en, .cfg, .cmd, .cmd_push, .cmd_pending, .done_count
    );

    cmprs_mb_sequencer cmprs_mb_sequencer_inst (
        .xclk, .arst_n, .frame_en, .cmd, .cmd_push, .mb_pre_end,
        .mb_pre_start, .mb_cmd, .cmd_pending
    );

    cmprs_pixel_buf_iface cmprs_pixel_buf_iface_inst (
        .xclk, .arst_n, .frame_en, .cfg, .mb_pre_start, .mb_cmd, .buf_di,
        .buf_ra, .buf_rd, .mb_pre_end, .mb_release_buf, .beat
    );

    cmprs_tile_buf cmprs_tile_buf_inst (
        .xclk,
        .wr_en   (buf_wr_en),
        .wr_addr (buf_wr_addr),
        .wr_data (buf_wr_data),
        .ra      (buf_ra),
        .rd      (buf_rd),
        .rdata   (buf_di)
    );

    cmprs_pixel_out cmprs_pixel_out_inst (
        .xclk, .arst_n, .frame_en, .beat,
        .pix_data, .pix_first, .pix_valid, .done_count
    );

endmodule

// File: verif/tb_cmprs_tasks.svh
/* testbench helpers: AXI4-Lite master tasks, tile buffer fill, value check
   and the reference macroblock address model */
`ifndef TB_CMPRS_TASKS_SVH
`define TB_CMPRS_TASKS_SVH

task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end_with_fail();
    end
endtask

task automatic wait_write_accept();
    @(negedge xclk);
    while (!(axi_awready && axi_wready)) @(negedge xclk);
    @(posedge xclk);                                // address and data taken here
    #TDRV;
    axi_awvalid = 1'b0;
    axi_wvalid  = 1'b0;
endtask

task automatic wait_write_resp();
    while (!axi_bvalid) @(negedge xclk);
    check_eq("axi_bresp", 32'(axi_bresp), 32'd0);
    @(posedge xclk);                                // bready high, response taken
    #TDRV;
endtask

task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
    @(posedge xclk);
    #TDRV;
    axi_awaddr  = addr;
    axi_wdata   = data;
    axi_awvalid = 1'b1;
    axi_wvalid  = 1'b1;
    wait_write_accept();
    wait_write_resp();
endtask

task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
    @(posedge xclk);
    #TDRV;
    axi_araddr  = addr;
    axi_arvalid = 1'b1;
    @(negedge xclk);
    while (!axi_arready) @(negedge xclk);
    @(posedge xclk);
    #TDRV;
    axi_arvalid = 1'b0;
    while (!axi_rvalid) @(negedge xclk);
    data = axi_rdata;                               // held while rvalid is up
    check_eq("axi_rresp", 32'(axi_rresp), 32'd0);
    @(posedge xclk);
    #TDRV;
endtask

// pixel = low byte of (address * 7 + page)
function automatic cmprs_pkg::pix_t fill_value(input cmprs_pkg::buf_addr_t a);
    int v;
    v = int'(a) * 7 + int'(a[11:10]);
    return v[7:0];
endfunction

task automatic fill_buffer();
    for (int a = 0; a < 4096; a++) begin
        @(posedge xclk);
        #TDRV;
        buf_wr_en   = 1'b1;
        buf_wr_addr = 12'(a);
        buf_wr_data = fill_value(12'(a));
    end
    @(posedge xclk);
    #TDRV;
    buf_wr_en = 1'b0;
endtask

// address of pixel (x, y), rows restart at the start page
function automatic cmprs_pkg::buf_addr_t ref_addr(input int start_page, input int mb_x,
                                                   input int x, input int y);
    int h;
    int w;
    int t;
    int p;
    int page;
    int off;
    h    = int'(cfg_val.mb_h_m1) + 1;
    w    = cfg_val.tile_col_width ? 32 : 16;       // tile column width
    t    = 16 << cfg_val.tile_width;               // tile width, one per page
    p    = mb_x + x;
    page = (start_page + p / t) % 4;
    off  = ((p % t) / w) * w * h + y * w + p % w;
    return 12'(page * 1024 + off);
endfunction

task automatic add_expected_mb(input int start_page, input int mb_x);
    for (int y = 0; y <= int'(cfg_val.mb_h_m1); y++) begin
        for (int x = 0; x <= int'(cfg_val.mb_w_m1); x++) begin
            exp_data.push_back(fill_value(ref_addr(start_page, mb_x, x, y)));
            exp_first.push_back(x == 0 && y == 0);
        end
    end
endtask

`endif

// File: verif/tb_cmprs.sv
/* tb_cmprs: directed testbench of the compressor front end, acts as AXI4-Lite
   master and as the memory controller that fills the tile buffer */
`timescale 1ns/1ns

module tb_cmprs;

    localparam int TDRV           = 1;      // drive delay after the rising edge
    localparam int TIMEOUT_CYCLES = 20000;  // fill ~4100, six macroblocks and bus ~3500

    logic                  xclk;
    logic                  arst_n;
    logic [3:0]            axi_awaddr;
    logic                  axi_awvalid;
    logic                  axi_awready;
    logic [31:0]           axi_wdata;
    logic                  axi_wvalid;
    logic                  axi_wready;
    logic [1:0]            axi_bresp;
    logic                  axi_bvalid;
    logic                  axi_bready;
    logic [3:0]            axi_araddr;
    logic                  axi_arvalid;
    logic                  axi_arready;
    logic [31:0]           axi_rdata;
    logic [1:0]            axi_rresp;
    logic                  axi_rvalid;
    logic                  axi_rready;
    logic                  buf_wr_en;
    cmprs_pkg::buf_addr_t  buf_wr_addr;
    cmprs_pkg::pix_t       buf_wr_data;
    cmprs_pkg::pix_t       pix_data;
    logic                  pix_first;
    logic                  pix_valid;
    logic                  mb_release_buf;
    cmprs_pkg::pix_t       got_data [$];    // beats seen at the output
    logic                  got_first [$];
    cmprs_pkg::pix_t       exp_data [$];    // model of the stream
    logic                  exp_first [$];
    cmprs_pkg::cmprs_cfg_t cfg_val;         // configuration last written
    int                    release_cnt = 0;
    int                    mb_done_exp = 0; // macroblocks that must run to the end
    int                    cycle_cnt   = 0;

    `include "tb_cmprs_tasks.svh"

    cmprs_front cmprs_front_inst (.*);

    initial begin
        xclk = 1'b0;
        forever #4 xclk = ~xclk;  // 8 ns period
    end

    // monitor on the falling edge, outputs are settled there
    always @(negedge xclk) begin
        if (pix_valid) begin
            got_data.push_back(pix_data);
            got_first.push_back(pix_first);
        end
        if (mb_release_buf) release_cnt++;
    end

    always @(posedge xclk) begin
        cycle_cnt++;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            end_with_fail();
        end
    end

    task automatic end_with_fail();
        $display("Testbench failed");
        $fatal(1);
    endtask

    // tile_w code 0..3 is 16..128 pixels, col_w code 0/1 is 16/32
    function automatic cmprs_pkg::cmprs_cfg_t make_cfg(input cmprs_pkg::conv_mode_e mode,
            input int mb_w, input int mb_h, input int tile_w, input int col_w);
        cmprs_pkg::cmprs_cfg_t c;
        c.conv_mode      = mode;
        c.mb_w_m1        = 6'(mb_w - 1);
        c.mb_h_m1        = 6'(mb_h - 1);
        c.tile_width     = 2'(tile_w);
        c.tile_col_width = 1'(col_w);
        return c;
    endfunction

    function automatic logic [31:0] cfg_word(input cmprs_pkg::cmprs_cfg_t c);
        return {{(32 - $bits(c)){1'b0}}, c};
    endfunction

    task automatic set_cfg(input cmprs_pkg::cmprs_cfg_t c);
        cfg_val = c;
        axi_write(cmprs_pkg::REG_CFG, cfg_word(c));
    endtask

    task automatic write_cmd(input int page, input int mb_x);
        cmprs_pkg::mb_cmd_t m;
        m.start_page   = 2'(page);
        m.macroblock_x = 7'(mb_x);
        axi_write(cmprs_pkg::REG_CMD, {23'b0, m});
    endtask

    task automatic push_cmd(input int page, input int mb_x);
        write_cmd(page, mb_x);
        add_expected_mb(page, mb_x);
        mb_done_exp++;
    endtask

    task automatic wait_not_pending();
        logic [31:0] st;
        axi_read(cmprs_pkg::REG_STATUS, st);
        while (st[16]) axi_read(cmprs_pkg::REG_STATUS, st);  // bit 16 is command pending
    endtask

    task automatic clear_stream();
        got_data.delete();
        got_first.delete();
        exp_data.delete();
        exp_first.delete();
    endtask

    // whole stream against the model, then the release of the last macroblock
    task automatic check_stream();
        int n;
        n = exp_data.size();
        @(posedge xclk);
        while (got_data.size() < n) @(posedge xclk);
        repeat (8) @(posedge xclk);                  // no beats after the last one
        check_eq("pix_valid beat count", got_data.size(), n);
        for (int i = 0; i < n; i++) begin
            check_eq($sformatf("pix_data[%0d]", i), 32'(got_data[i]), 32'(exp_data[i]));
            check_eq($sformatf("pix_first[%0d]", i), 32'(got_first[i]), 32'(exp_first[i]));
        end
        while (release_cnt < mb_done_exp) @(posedge xclk);  // color18 frees after its pixels
    endtask

    task automatic test_regs();
        logic [31:0] rd;
        cmprs_pkg::cmprs_cfg_t c1;
        cmprs_pkg::cmprs_cfg_t c2;
        c1 = make_cfg(cmprs_pkg::JP4, 16, 16, 0, 0);
        c2 = make_cfg(cmprs_pkg::COLOR18, 18, 18, 1, 1);
        axi_write(cmprs_pkg::REG_CTRL, 32'h1);
        set_cfg(c1);
        axi_read(cmprs_pkg::REG_CTRL, rd);
        check_eq("axi_rdata ctrl", rd, 32'h1);
        axi_read(cmprs_pkg::REG_CFG, rd);
        check_eq("axi_rdata cfg", rd, cfg_word(c1));
        axi_read(cmprs_pkg::REG_STATUS, rd);
        check_eq("axi_rdata status", rd, 32'h0);
        axi_bready = 1'b0;                           // response held back
        @(posedge xclk);
        #TDRV;
        axi_awaddr  = cmprs_pkg::REG_CTRL;
        axi_wdata   = 32'h1;
        axi_awvalid = 1'b1;
        axi_wvalid  = 1'b1;
        @(negedge xclk);
        while (!axi_awready) @(negedge xclk);
        @(posedge xclk);
        #TDRV;
        axi_awaddr = cmprs_pkg::REG_CFG;             // next write waits behind bvalid
        axi_wdata  = cfg_word(c2);
        repeat (3) begin
            @(negedge xclk);
            check_eq("axi_bvalid", 32'(axi_bvalid), 32'd1);
            check_eq("axi_awready", 32'(axi_awready), 32'd0);
        end
        @(posedge xclk);
        #TDRV;
        axi_bready = 1'b1;
        wait_write_accept();
        wait_write_resp();
        axi_read(cmprs_pkg::REG_CFG, rd);
        check_eq("axi_rdata cfg", rd, cfg_word(c2));
    endtask

    task automatic test_single_jp4();
        clear_stream();
        set_cfg(make_cfg(cmprs_pkg::JP4, 16, 16, 0, 0));
        push_cmd(0, 0);
        check_stream();
    endtask

    // starts in tile column 1 of page 1 and runs into page 2
    task automatic test_color18_cross();
        clear_stream();
        set_cfg(make_cfg(cmprs_pkg::COLOR18, 18, 18, 1, 0));
        push_cmd(1, 24);
        check_stream();
    endtask

    task automatic test_queued_jp4();
        logic [31:0] rd;
        axi_write(cmprs_pkg::REG_CTRL, 32'h0);       // clears done_count
        axi_write(cmprs_pkg::REG_CTRL, 32'h1);
        clear_stream();
        set_cfg(make_cfg(cmprs_pkg::JP4, 16, 16, 2, 0));
        wait_not_pending();
        push_cmd(0, 8);
        wait_not_pending();
        push_cmd(1, 40);
        wait_not_pending();
        push_cmd(2, 56);                             // spills into page 3
        check_stream();
        axi_read(cmprs_pkg::REG_STATUS, rd);
        check_eq("axi_rdata status", rd, 32'd3);
    endtask

    task automatic test_frame_abort();
        logic [31:0] rd;
        clear_stream();
        set_cfg(make_cfg(cmprs_pkg::JP4, 16, 16, 0, 0));
        write_cmd(2, 0);                             // cut short, never counted
        @(posedge xclk);
        while (got_data.size() < 100) @(posedge xclk);
        axi_write(cmprs_pkg::REG_CTRL, 32'h0);
        repeat (20) begin
            @(negedge xclk);
            check_eq("pix_valid", 32'(pix_valid), 32'd0);
        end
        axi_read(cmprs_pkg::REG_STATUS, rd);
        check_eq("axi_rdata status", rd, 32'h0);
        axi_write(cmprs_pkg::REG_CTRL, 32'h1);
        clear_stream();
        set_cfg(make_cfg(cmprs_pkg::JP4DIFF, 16, 16, 2, 1));
        push_cmd(3, 24);
        check_stream();
    endtask

    task automatic test_release_count();
        repeat (400) @(posedge xclk);                // room for a stray pulse
        check_eq("mb_release_buf pulses", release_cnt, 32'd6);
    endtask

    initial begin
        arst_n      = 1'b0;
        axi_awaddr  = '0;
        axi_awvalid = 1'b0;
        axi_wdata   = '0;
        axi_wvalid  = 1'b0;
        axi_bready  = 1'b1;
        axi_araddr  = '0;
        axi_arvalid = 1'b0;
        axi_rready  = 1'b1;
        buf_wr_en   = 1'b0;
        buf_wr_addr = '0;
        buf_wr_data = '0;
        repeat (16) @(posedge xclk);
        #TDRV;
        arst_n = 1'b1;
        fill_buffer();
        test_regs();
        test_single_jp4();
        test_color18_cross();
        test_queued_jp4();
        test_frame_abort();
        test_release_count();
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: cmprs_front.f
+incdir+verif
verilog/cmprs_pkg.sv
verilog/cmprs_regs.sv
verilog/cmprs_mb_sequencer.sv
verilog/cmprs_pixel_buf_iface.sv
verilog/cmprs_tile_buf.sv
verilog/cmprs_pixel_out.sv
verilog/cmprs_front.sv
verif/tb_cmprs.sv

// File: Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing
TOP       := tb_cmprs
FILELIST  := cmprs_front.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) verif/tb_cmprs_tasks.svh

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
